//--- mipsCore_cfg.svh
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Architectural registers including r0
`define MIPS_REG_COUNT 32

// Memory depths in 32-bit words
`define MIPS_TEXT_WORDS 1024
`define MIPS_DM_WORDS 1024

`endif

//--- mipsPkg.sv
package mipsPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcodeE;

	// Function field under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23
	} functE;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_OR  = 3'd2,
		ALU_LUI = 3'd3
	} aluOpE;

	typedef enum logic [1:0] {
		NPC_SEQ    = 2'd0,
		NPC_BRANCH = 2'd1,
		NPC_JUMP   = 2'd2,
		NPC_REG    = 2'd3
	} npcOpE;

	// All zero is a nop
	typedef struct packed {
		logic       regWrite;
		logic       memWrite;
		logic       memToReg;
		logic       linkWrite;
		aluOpE      aluOp;
		logic       aluSrcImm;
		logic       zeroExtend;
		npcOpE      npcOp;
		logic [1:0] tNew;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} ifIdT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0]  destReg;
		ctrlT        ctrl;
	} decExT;

	// tNew here already counts from the memory stage
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [4:0]  destReg;
		ctrlT        ctrl;
	} exMemT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluResult;
		logic [31:0] loadData;
		logic [4:0]  destReg;
		ctrlT        ctrl;
	} memWbT;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  regNum;
		logic [31:0] data;
	} wbEventT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] addr;
		logic [31:0] data;
	} storeEventT;

endpackage

//--- pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
	parameter type payloadT = logic [31:0]
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    en,
	input  logic    clr,
	input  payloadT d,
	output payloadT q
);

	// Zero payload behaves as a nop downstream
	always_ff @(posedge clk) begin
		if (rst || clr) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

//--- ifu.sv
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module ifu (
	input  logic           clk,
	input  logic           rst,
	input  logic           pcWrite,
	input  mipsPkg::npcOpE npcOp,
	input  logic           branchTaken,
	input  logic [15:0]    offset,
	input  logic [25:0]    jumpIndex,
	input  logic [31:0]    regTarget,
	input  logic [31:0]    decodePc,
	output logic [31:0]    pc
);
	logic [31:0] slotPc;
	logic [31:0] nextPc;

	// Targets are relative to the delay slot
	assign slotPc = decodePc + 32'd4;

	always_comb begin
		case (npcOp)
			mipsPkg::NPC_BRANCH: begin
				nextPc = branchTaken ? slotPc + {{14{offset[15]}}, offset, 2'b00} : pc + 32'd4;
			end
			mipsPkg::NPC_JUMP: begin
				nextPc = {slotPc[31:28], jumpIndex, 2'b00};
			end
			mipsPkg::NPC_REG: begin
				nextPc = regTarget;
			end
			default: begin
				nextPc = pc + 32'd4;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `MIPS_RESET_PC;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

endmodule

//--- ctrl.sv
`timescale 1ns/1ps

module ctrl (
	input  logic [31:0]   instr,
	output mipsPkg::ctrlT ctrl,
	output logic [4:0]    destReg
);
	mipsPkg::opcodeE op;
	mipsPkg::functE  fn;
	logic            useRd;

	assign op = mipsPkg::opcodeE'(instr[31:26]);
	assign fn = mipsPkg::functE'(instr[5:0]);

	// Unknown words fall through as nop
	always_comb begin
		ctrl = '0;
		useRd = 1'b0;
		case (op)
			mipsPkg::OP_SPECIAL: begin
				case (fn)
					mipsPkg::FN_ADDU: begin
						ctrl.regWrite = 1'b1;
						ctrl.tNew = 2'd1;
						useRd = 1'b1;
					end
					mipsPkg::FN_SUBU: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::ALU_SUB;
						ctrl.tNew = 2'd1;
						useRd = 1'b1;
					end
					mipsPkg::FN_JR: begin
						ctrl.npcOp = mipsPkg::NPC_REG;
					end
					default: ;
				endcase
			end
			mipsPkg::OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_OR;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.tNew = 2'd1;
			end
			mipsPkg::OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_LUI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.tNew = 2'd1;
			end
			mipsPkg::OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.tNew = 2'd2;
			end
			mipsPkg::OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			mipsPkg::OP_BEQ: begin
				ctrl.npcOp = mipsPkg::NPC_BRANCH;
			end
			mipsPkg::OP_JAL: begin
				// Link value is known as soon as jal leaves decode
				ctrl.regWrite = 1'b1;
				ctrl.linkWrite = 1'b1;
				ctrl.npcOp = mipsPkg::NPC_JUMP;
			end
			default: ;
		endcase
	end

	assign destReg = !ctrl.regWrite ? 5'd0 :
		ctrl.linkWrite ? 5'd31 :
		useRd ? instr[15:11] : instr[20:16];

endmodule

//--- grf.sv
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module grf (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);
	logic [31:0] regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write shows through to decode
	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  mipsPkg::aluOpE aluOp,
	input  logic [31:0]    srcA,
	input  logic [31:0]    srcB,
	input  logic [31:0]    cmpA,
	input  logic [31:0]    cmpB,
	output logic [31:0]    result,
	output logic           equal
);

	// Execute half
	always_comb begin
		case (aluOp)
			mipsPkg::ALU_ADD: begin
				result = srcA + srcB;
			end
			mipsPkg::ALU_SUB: begin
				result = srcA - srcB;
			end
			mipsPkg::ALU_OR: begin
				result = srcA | srcB;
			end
			mipsPkg::ALU_LUI: begin
				result = {srcB[15:0], 16'h0000};
			end
			default: begin
				result = srcA + srcB;
			end
		endcase
	end

	// Decode half for beq
	assign equal = (cmpA == cmpB);

endmodule

//--- hazard.sv
`timescale 1ns/1ps

module hazard (
	input  logic [4:0]    decRs,
	input  logic [4:0]    decRt,
	input  mipsPkg::ctrlT decCtrl,
	input  logic [4:0]    exDest,
	input  logic [1:0]    exTNew,
	input  logic [4:0]    memDest,
	input  logic [1:0]    memTNew,
	output logic          pcWrite,
	output logic          ifIdEn,
	output logic          idExClr
);
	logic       decodeUse;
	logic       rsUsed;
	logic       rtUsed;
	logic [1:0] rsTUse;
	logic [1:0] rtTUse;
	logic       rsStall;
	logic       rtStall;
	logic       stall;

	function automatic logic notReady(
		input logic [4:0] src,
		input logic [4:0] dest,
		input logic [1:0] tNew,
		input logic [1:0] tUse
	);
		return (src != 5'd0) && (src == dest) && (tNew > tUse);
	endfunction

	// beq and jr compare in decode
	assign decodeUse = (decCtrl.npcOp == mipsPkg::NPC_BRANCH) ||
		(decCtrl.npcOp == mipsPkg::NPC_REG);

	assign rsUsed = decodeUse || decCtrl.memWrite ||
		(decCtrl.regWrite && !decCtrl.linkWrite && decCtrl.aluOp != mipsPkg::ALU_LUI);
	assign rtUsed = (decCtrl.npcOp == mipsPkg::NPC_BRANCH) || decCtrl.memWrite ||
		(decCtrl.regWrite && !decCtrl.aluSrcImm && !decCtrl.linkWrite);

	// Store data is only needed in the memory stage
	assign rsTUse = decodeUse ? 2'd0 : 2'd1;
	assign rtTUse = (decCtrl.npcOp == mipsPkg::NPC_BRANCH) ? 2'd0 :
		decCtrl.memWrite ? 2'd2 : 2'd1;

	assign rsStall = rsUsed && (notReady(decRs, exDest, exTNew, rsTUse) ||
		notReady(decRs, memDest, memTNew, rsTUse));
	assign rtStall = rtUsed && (notReady(decRt, exDest, exTNew, rtTUse) ||
		notReady(decRt, memDest, memTNew, rtTUse));
	assign stall = rsStall || rtStall;

	assign pcWrite = !stall;
	assign ifIdEn = !stall;
	assign idExClr = stall;

endmodule

//--- mips.sv
`timescale 1ns/1ps

module mips (
	input  logic                clk,
	input  logic                rst,
	output logic [31:0]         imemAddr,
	input  logic [31:0]         imemData,
	output logic [31:0]         dmemAddr,
	output logic [31:0]         dmemWData,
	output logic                dmemWe,
	input  logic [31:0]         dmemRData,
	output logic                wbValid,
	output mipsPkg::wbEventT    wbEvent,
	output mipsPkg::storeEventT storeEvent
);
	mipsPkg::ifIdT  ifIdD, ifIdQ;
	mipsPkg::decExT idExD, idExQ;
	mipsPkg::exMemT exMemD, exMemQ;
	mipsPkg::memWbT memWbD, memWbQ;
	mipsPkg::ctrlT  decCtrl;

	logic        pcWrite, ifIdEn, idExClr;
	logic [31:0] fetchPc;
	logic [4:0]  decRs, decRt, decDest, memRt;
	logic [31:0] grfRs, grfRt, decRsVal, decRtVal, decImm;
	logic        branchEqual, branchTaken;
	logic [31:0] exRsVal, exRtVal, exSrcB, aluResult;
	logic [31:0] wbData;

	// Nearest ready producer wins and source zero never matches
	function automatic logic [31:0] pickFwd(
		input logic [4:0]  src,
		input logic [31:0] regVal,
		input logic [4:0]  nearDest,
		input logic        nearReady,
		input logic [31:0] nearVal,
		input logic [4:0]  farDest,
		input logic        farReady,
		input logic [31:0] farVal
	);
		if (src != 5'd0 && src == nearDest && nearReady)
			return nearVal;
		if (src != 5'd0 && src == farDest && farReady)
			return farVal;
		return regVal;
	endfunction

	//////////////////////////////
	// Fetch
	ifu ifuInst (
		.clk(clk),
		.rst(rst),
		.pcWrite(pcWrite),
		.npcOp(decCtrl.npcOp),
		.branchTaken(branchTaken),
		.offset(ifIdQ.instr[15:0]),
		.jumpIndex(ifIdQ.instr[25:0]),
		.regTarget(decRsVal),
		.decodePc(ifIdQ.pc),
		.pc(fetchPc)
	);

	assign imemAddr = fetchPc;
	assign ifIdD = '{pc: fetchPc, instr: imemData};

	pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
		.clk(clk), .rst(rst), .en(ifIdEn), .clr(1'b0), .d(ifIdD), .q(ifIdQ)
	);

	//////////////////////////////
	// Decode
	assign decRs = ifIdQ.instr[25:21];
	assign decRt = ifIdQ.instr[20:16];

	ctrl ctrlInst (.instr(ifIdQ.instr), .ctrl(decCtrl), .destReg(decDest));

	grf grfInst (
		.clk(clk), .rst(rst), .we(wbValid), .waddr(memWbQ.destReg), .wdata(wbData),
		.raddr1(decRs), .raddr2(decRt), .rdata1(grfRs), .rdata2(grfRt)
	);

	// Execute only offers a jal link and the grf covers writeback
	assign decRsVal = pickFwd(decRs, grfRs, idExQ.destReg, idExQ.ctrl.tNew == 2'd0,
		idExQ.pc + 32'd8, exMemQ.destReg, exMemQ.ctrl.tNew == 2'd0, exMemQ.aluResult);
	assign decRtVal = pickFwd(decRt, grfRt, idExQ.destReg, idExQ.ctrl.tNew == 2'd0,
		idExQ.pc + 32'd8, exMemQ.destReg, exMemQ.ctrl.tNew == 2'd0, exMemQ.aluResult);

	assign branchTaken = (decCtrl.npcOp == mipsPkg::NPC_BRANCH) && branchEqual;
	assign decImm = decCtrl.zeroExtend ? {16'h0000, ifIdQ.instr[15:0]} :
		{{16{ifIdQ.instr[15]}}, ifIdQ.instr[15:0]};

	assign idExD = '{pc: ifIdQ.pc, instr: ifIdQ.instr, rsVal: decRsVal, rtVal: decRtVal,
		imm: decImm, destReg: decDest, ctrl: decCtrl};

	hazard hazardInst (
		.decRs(decRs), .decRt(decRt), .decCtrl(decCtrl),
		.exDest(idExQ.destReg), .exTNew(idExQ.ctrl.tNew),
		.memDest(exMemQ.destReg), .memTNew(exMemQ.ctrl.tNew),
		.pcWrite(pcWrite), .ifIdEn(ifIdEn), .idExClr(idExClr)
	);

	pipeReg #(.payloadT(mipsPkg::decExT)) idExReg (
		.clk(clk), .rst(rst), .en(1'b1), .clr(idExClr), .d(idExD), .q(idExQ)
	);

	//////////////////////////////
	// Execute
	// A load in memory is not ready yet so its value comes later from writeback
	assign exRsVal = pickFwd(idExQ.instr[25:21], idExQ.rsVal,
		exMemQ.destReg, exMemQ.ctrl.tNew == 2'd0, exMemQ.aluResult,
		memWbQ.destReg, wbValid, wbData);
	assign exRtVal = pickFwd(idExQ.instr[20:16], idExQ.rtVal,
		exMemQ.destReg, exMemQ.ctrl.tNew == 2'd0, exMemQ.aluResult,
		memWbQ.destReg, wbValid, wbData);
	assign exSrcB = idExQ.ctrl.aluSrcImm ? idExQ.imm : exRtVal;

	alu aluInst (
		.aluOp(idExQ.ctrl.aluOp), .srcA(exRsVal), .srcB(exSrcB),
		.cmpA(decRsVal), .cmpB(decRtVal), .result(aluResult), .equal(branchEqual)
	);

	always_comb begin
		exMemD.pc = idExQ.pc;
		exMemD.instr = idExQ.instr;
		exMemD.aluResult = idExQ.ctrl.linkWrite ? idExQ.pc + 32'd8 : aluResult;
		exMemD.storeData = exRtVal;
		exMemD.destReg = idExQ.destReg;
		exMemD.ctrl = idExQ.ctrl;
		// One stage closer to ready
		exMemD.ctrl.tNew = (idExQ.ctrl.tNew != 2'd0) ? idExQ.ctrl.tNew - 2'd1 : 2'd0;
	end

	pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
		.clk(clk), .rst(rst), .en(1'b1), .clr(1'b0), .d(exMemD), .q(exMemQ)
	);

	//////////////////////////////
	// Memory
	assign memRt = exMemQ.instr[20:16];
	assign dmemAddr = exMemQ.aluResult;
	assign dmemWData = (wbValid && memRt == memWbQ.destReg) ? wbData : exMemQ.storeData;
	assign dmemWe = exMemQ.ctrl.memWrite;
	assign storeEvent = '{pc: exMemQ.pc, addr: dmemAddr, data: dmemWData};

	assign memWbD = '{pc: exMemQ.pc, aluResult: exMemQ.aluResult, loadData: dmemRData,
		destReg: exMemQ.destReg, ctrl: exMemQ.ctrl};

	pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
		.clk(clk), .rst(rst), .en(1'b1), .clr(1'b0), .d(memWbD), .q(memWbQ)
	);

	//////////////////////////////
	// Writeback
	assign wbData = memWbQ.ctrl.memToReg ? memWbQ.loadData : memWbQ.aluResult;
	assign wbValid = memWbQ.ctrl.regWrite && (memWbQ.destReg != 5'd0);
	assign wbEvent = '{pc: memWbQ.pc, regNum: memWbQ.destReg, data: wbData};

endmodule

//--- mips_asserts.sv
`timescale 1ns/1ps

module mipsAsserts (
	input logic             clk,
	input logic             rst,
	input logic             dmemWe,
	input logic             wbValid,
	input mipsPkg::wbEventT wbEvent,
	input logic [31:0]      imemAddr
);

	// Stage registers are cleared after the first reset edge
	noEventsInReset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> (!dmemWe && !wbValid))
		else $error("store or register write seen during reset");

	// A retiring write carries a real register and known data
	wbRegNonZero: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> (wbEvent.regNum != 5'd0 && !$isunknown(wbEvent)))
		else $error("register write event targets register zero or has unknown bits");

	fetchAligned: assert property (@(posedge clk) disable iff (rst)
		imemAddr[1:0] == 2'b00)
		else $error("instruction address not word aligned");

endmodule

//--- mips_tb.sv
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module mips_tb;
	localparam int PAT_WORDS = 256;
	localparam int PROG_WORDS = 64;
	localparam int REC_BASE = 64;
	localparam int DM_AW = $clog2(`MIPS_DM_WORDS);
	localparam int WATCH_CYCLES = PROG_WORDS * 20 + 16;

	logic clk;
	logic rst;
	logic [31:0] imemAddr, imemData, dmemAddr, dmemWData, dmemRData;
	logic dmemWe, wbValid;
	mipsPkg::wbEventT wbEvent;
	mipsPkg::storeEventT storeEvent;

	logic [31:0] pat [PAT_WORDS];
	logic [31:0] dm [`MIPS_DM_WORDS];
	logic [31:0] progOff;
	logic [DM_AW-1:0] dmIdx;

	mipsPkg::wbEventT wbExp [$];
	mipsPkg::storeEventT stExp [$];
	int wbIdx = 0;
	int stIdx = 0;
	int wbErrors = 0;
	int stErrors = 0;
	int countErrors = 0;

	mips dut_i (.*);

	bind mips mipsAsserts assertsInst (.*);

	//////////////////////////////
	// Memory models
	assign progOff = imemAddr - `MIPS_RESET_PC;
	assign imemData = (progOff < PROG_WORDS * 4) ? pat[{2'b00, progOff[7:2]}] : 32'h0;
	assign dmIdx = dmemAddr[DM_AW+1:2];
	assign dmemRData = dm[dmIdx];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic loadPatterns();
		int i;
		mipsPkg::wbEventT wbRec;
		mipsPkg::storeEventT stRec;
		$readmemh("mips_patterns.mem", pat);
		i = REC_BASE;
		while (i + 3 < PAT_WORDS && pat[i] != 32'd0) begin
			if (pat[i] == 32'd1) begin
				wbRec.pc = pat[i+1];
				wbRec.regNum = pat[i+2][4:0];
				wbRec.data = pat[i+3];
				wbExp.push_back(wbRec);
			end else begin
				stRec.pc = pat[i+1];
				stRec.addr = pat[i+2];
				stRec.data = pat[i+3];
				stExp.push_back(stRec);
			end
			i = i + 4;
		end
	endtask

	//////////////////////////////
	// Event checking
	always @(posedge clk) begin
		if (!rst && wbValid) begin
			assert (wbIdx < wbExp.size()) else begin
				$display("unexpected extra register write to r%0d from pc %h",
					wbEvent.regNum, wbEvent.pc);
				countErrors++;
			end
			if (wbIdx < wbExp.size()) begin
				assert (wbEvent == wbExp[wbIdx]) else begin
					$display("error regwrite #%0d: expected pc %h r%0d %h, actual pc %h r%0d %h",
						wbIdx, wbExp[wbIdx].pc, wbExp[wbIdx].regNum, wbExp[wbIdx].data,
						wbEvent.pc, wbEvent.regNum, wbEvent.data);
					wbErrors++;
				end
			end
			wbIdx++;
		end
		if (!rst && dmemWe) begin
			assert (stIdx < stExp.size()) else begin
				$display("unexpected extra store to %h from pc %h",
					storeEvent.addr, storeEvent.pc);
				countErrors++;
			end
			if (stIdx < stExp.size()) begin
				assert (storeEvent == stExp[stIdx]) else begin
					$display("error store #%0d: expected pc %h [%h] %h, actual pc %h [%h] %h",
						stIdx, stExp[stIdx].pc, stExp[stIdx].addr, stExp[stIdx].data,
						storeEvent.pc, storeEvent.addr, storeEvent.data);
					stErrors++;
				end
			end
			stIdx++;
			dm[dmIdx] <= dmemWData;
		end
	end

	// Watchdog
	initial begin
		#(WATCH_CYCLES * 8);
		$display("timeout: only %0d of %0d register writes and %0d of %0d stores arrived",
			wbIdx, wbExp.size(), stIdx, stExp.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	initial begin
		rst = 1'b1;
		for (int i = 0; i < `MIPS_DM_WORDS; i++) begin
			dm[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0001);
		end
		loadPatterns();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		wait (wbIdx >= wbExp.size() && stIdx >= stExp.size());
		// Drain so that late extra events are still caught
		repeat (40) @(posedge clk);
		assert (wbIdx == wbExp.size() && stIdx == stExp.size()) else begin
			$display("event count mismatch: %0d register writes and %0d stores seen",
				wbIdx, stIdx);
			countErrors++;
		end
		$display("regwrite errors %0d, store errors %0d, count errors %0d",
			wbErrors, stErrors, countErrors);
		if (wbErrors + stErrors + countErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- mips_patterns.mem
// Words 0x00-0x3f: program words, first word at the reset PC
// From 0x40: records of kind (1 reg write, 2 store, 0 end), pc, target, value
@00
34011234 3c02abcd 00221821 00612023 348500ff 34005555 00053021 ac050010
8c070010 00e14021 ac080014 10210002 34090009 340adead 10220005 340b000b
0c000c18 340c000c 340d000d 1000ffff 00000000 340e00ee 00000000 00000000
340f000f 03e00008 34100010 340e00ee
@40
00000001 00003000 00000001 00001234
00000001 00003004 00000002 abcd0000
00000001 00003008 00000003 abcd1234
00000001 0000300c 00000004 abcd0000
00000001 00003010 00000005 abcd00ff
00000001 00003018 00000006 abcd00ff
00000002 0000301c 00000010 abcd00ff
00000001 00003020 00000007 abcd00ff
00000001 00003024 00000008 abcd1333
00000002 00003028 00000014 abcd1333
00000001 00003030 00000009 00000009
00000001 0000303c 0000000b 0000000b
00000001 00003040 0000001f 00003048
00000001 00003044 0000000c 0000000c
00000001 00003060 0000000f 0000000f
00000001 00003068 00000010 00000010
00000001 00003048 0000000d 0000000d
00000000 00000000 00000000 00000000

//--- mips.f
+incdir+.
mipsPkg.sv
pipeReg.sv
ifu.sv
ctrl.sv
grf.sv
alu.sv
hazard.sv
mips.sv
mips_asserts.sv
mips_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips.f --top-module mips_tb -o mips_sim
./obj_dir/mips_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	exit 1
fi
